/* Makefile */
VERILATOR ?= verilator
FLAGS     = --timing --assert
TOP       = fpga_core_tb
FILELIST  = fpga_core.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Testbench failed
PASS_MSG  = Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/bar_register_file.sv */
// BAR0 register file
`timescale 1ns/1ns

module bar_register_file (
    input  logic                          clk,
    input  logic                          reset,
    input  pcie_example_pkg::reg_access_t acc,
    input  logic                          acc_valid,
    output logic [31:0]                   rd_data,
    output logic [7:0]                    rd_tag,
    output logic                          rd_valid
);
    import pcie_example_pkg::*;

    logic [31:0] regs [BAR0_REG_COUNT];
    logic        do_wr;
    logic        do_rd;

    assign do_wr = acc_valid && acc.wr;
    assign do_rd = acc_valid && !acc.wr;

    // register array cleared on reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BAR0_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (do_wr) begin
            regs[acc.idx] <= acc.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= do_rd;
        end
    end

    // read data and tag in one stage.
    always_ff @(posedge clk) begin
        if (do_rd) begin
            rd_data <= regs[acc.idx];
            rd_tag  <= acc.tag;   // carried along for the completion.
        end
    end

endmodule

/* design/cc_completion_builder.sv */
// Completion builder
`timescale 1ns/1ns

module cc_completion_builder (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            rd_data,
    input  logic [7:0]             rd_tag,
    input  logic                   rd_valid,
    input  logic [7:0]             ur_tag,
    input  logic                   ur_valid,
    output pcie_example_pkg::cpl_t cc_cpl,
    output logic                   cc_valid
);
    import pcie_example_pkg::*;

    logic [7:0] ur_tag_d;
    logic       ur_valid_d;

    // ur path lags one stage to line up with the register read.
    always_ff @(posedge clk) begin
        if (reset) begin
            ur_valid_d <= 1'b0;
            cc_valid   <= 1'b0;
        end else begin
            ur_valid_d <= ur_valid;
            cc_valid   <= rd_valid || ur_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        ur_tag_d <= ur_tag;
        if (rd_valid) begin
            cc_cpl <= '{tag: rd_tag, status: CPL_SC, data: rd_data};
        end else begin
            cc_cpl <= '{tag: ur_tag_d, status: CPL_UR, data: '0}; // ur carries no data.
        end
    end

    // both sources share one slot per cycle.
    assert property (@(posedge clk) disable iff (reset)
        !(rd_valid && ur_valid_d))
        else $error("read and ur completion collide");

endmodule

/* design/cq_request_decoder.sv */
// Completer request decoder
`timescale 1ns/1ns

module cq_request_decoder (
    input  logic                          clk,
    input  logic                          reset,
    input  pcie_example_pkg::cq_desc_t    cq_desc,
    input  logic                          cq_valid,
    output pcie_example_pkg::reg_access_t acc,
    output logic                          acc_valid,
    output logic [7:0]                    ur_tag,
    output logic                          ur_valid,
    output logic [3:0]                    led_set,
    output logic                          led_valid,
    output logic                          err_pulse
);
    import pcie_example_pkg::*;

    logic [3:0] req_type;
    logic       is_rd;
    logic       is_wr;
    logic       in_bar0;
    logic       hit_acc;
    logic       hit_ur;
    logic       hit_led;

    assign req_type = cq_desc.mem.req_type; // same bits in both views.
    assign is_rd    = (req_type == REQ_MEM_RD);
    assign is_wr    = (req_type == REQ_MEM_WR);

    // the one aperture check in the design.
    assign in_bar0 = (cq_desc.mem.bar_id == BAR0_ID) &&
                     (cq_desc.mem.addr[15:BAR0_ADDR_WIDTH] == '0);

    assign hit_acc = cq_valid && (is_rd || is_wr) && in_bar0;
    assign hit_ur  = cq_valid && is_rd && !in_bar0; // writes out of range are dropped.

    // messages are read through the msg view.
    assign hit_led = cq_valid && (req_type == REQ_MSG) &&
                     (cq_desc.msg.msg_code == MSG_LED_SET);

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_valid <= 1'b0;
            ur_valid  <= 1'b0;
            led_valid <= 1'b0;
            err_pulse <= 1'b0;
        end else begin
            acc_valid <= hit_acc;
            ur_valid  <= hit_ur;
            led_valid <= hit_led;
            // anything not serviced counts as unsupported.
            err_pulse <= cq_valid && !hit_acc && !hit_led;
        end
    end

    // payload follows the strobes.
    always_ff @(posedge clk) begin
        acc.wr      <= is_wr;
        acc.idx     <= cq_desc.mem.addr[BAR0_ADDR_WIDTH-1:0];
        acc.tag     <= cq_desc.mem.tag;
        acc.wr_data <= cq_desc.mem.wr_data;
        ur_tag      <= cq_desc.mem.tag;
        led_set     <= cq_desc.msg.payload[3:0];
    end

    // each request lands on at most one path.
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({acc_valid, ur_valid, led_valid}))
        else $error("decoder drove more than one request path");

endmodule

/* design/example_core_pcie.sv */
// Example PCIe completer core
`timescale 1ns/1ns

module example_core_pcie (
    input  logic                       clk,
    input  logic                       reset,
    input  pcie_example_pkg::cq_desc_t cq_desc,
    input  logic                       cq_valid,
    output pcie_example_pkg::cpl_t     cc_cpl,
    output logic                       cc_valid,
    output logic [3:0]                 led,
    output logic                       error_flag,
    output logic                       status_error_uncor
);
    import pcie_example_pkg::*;

    reg_access_t acc;
    logic        acc_valid;
    logic [7:0]  ur_tag;
    logic        ur_valid;
    logic [3:0]  led_set;
    logic        led_valid;
    logic        err_pulse;
    logic [31:0] rd_data;
    logic [7:0]  rd_tag;
    logic        rd_valid;

    cq_request_decoder cq_request_decoder_inst (
        .clk       (clk),
        .reset     (reset),
        .cq_desc   (cq_desc),
        .cq_valid  (cq_valid),
        .acc       (acc),
        .acc_valid (acc_valid),
        .ur_tag    (ur_tag),
        .ur_valid  (ur_valid),
        .led_set   (led_set),
        .led_valid (led_valid),
        .err_pulse (err_pulse)
    );

    bar_register_file bar_register_file_inst (
        .clk       (clk),
        .reset     (reset),
        .acc       (acc),
        .acc_valid (acc_valid),
        .rd_data   (rd_data),
        .rd_tag    (rd_tag),
        .rd_valid  (rd_valid)
    );

    cc_completion_builder cc_completion_builder_inst (
        .clk      (clk),
        .reset    (reset),
        .rd_data  (rd_data),
        .rd_tag   (rd_tag),
        .rd_valid (rd_valid),
        .ur_tag   (ur_tag),
        .ur_valid (ur_valid),
        .cc_cpl   (cc_cpl),
        .cc_valid (cc_valid)
    );

    // led state and error reporting.
    always_ff @(posedge clk) begin
        if (reset) begin
            led                <= '0;
            error_flag         <= 1'b0;
            status_error_uncor <= 1'b0;
        end else begin
            if (led_valid) begin
                led <= led_set;
            end
            if (err_pulse) begin
                error_flag <= 1'b1; // sticky until reset.
            end
            status_error_uncor <= err_pulse;
        end
    end

    assert property (@(posedge clk) reset |=> !cc_valid)
        else $error("completion during reset");

    // every read, good or unsupported, completes at fixed latency.
    assert property (@(posedge clk) disable iff (reset)
        cq_valid && (cq_desc.mem.req_type == REQ_MEM_RD) |-> ##CPL_LATENCY cc_valid)
        else $error("read completion missing or late");

endmodule

/* design/fpga_core.sv */
// FPGA core top level
`timescale 1ns/1ns

module fpga_core (
    input  logic                       clk,
    input  logic                       reset,

    // completer request
    input  pcie_example_pkg::cq_desc_t cq_desc,
    input  logic                       cq_valid,

    // completer completion
    output pcie_example_pkg::cpl_t     cc_cpl,
    output logic                       cc_valid,

    // gpio
    output logic [1:0]                 user_led_g,
    output logic                       user_led_r,
    output logic [1:0]                 front_led,

    output logic                       status_error_uncor
);

    // led bits 1:0 go to the green user leds, 3:2 to the front panel.
    example_core_pcie example_core_pcie_inst (
        .clk                (clk),
        .reset              (reset),
        .cq_desc            (cq_desc),
        .cq_valid           (cq_valid),
        .cc_cpl             (cc_cpl),
        .cc_valid           (cc_valid),
        .led                ({front_led, user_led_g}),
        .error_flag         (user_led_r),
        .status_error_uncor (status_error_uncor)
    );

endmodule

/* design/pcie_example_pkg.sv */
// PCIe example shared types
package pcie_example_pkg;

    // request types, top 4 bits of every descriptor.
    localparam logic [3:0] REQ_MEM_RD = 4'd0;
    localparam logic [3:0] REQ_MEM_WR = 4'd1;
    localparam logic [3:0] REQ_MSG    = 4'd2;

    localparam logic [7:0] MSG_LED_SET = 8'h10; // leds take payload[3:0].

    // BAR0 aperture.
    localparam logic [2:0] BAR0_ID         = 3'd0;
    localparam int         BAR0_REG_COUNT  = 16;
    localparam int         BAR0_ADDR_WIDTH = 4;

    localparam int CPL_LATENCY = 3; // cq_valid cycle to cc_valid cycle.

    // memory request view of a cq descriptor.
    typedef struct packed {
        logic [3:0]  req_type;
        logic [2:0]  bar_id;
        logic [7:0]  tag;
        logic [15:0] addr;      // dword address.
        logic        pad;
        logic [31:0] wr_data;
    } cq_mem_t;

    // message view of a cq descriptor.
    typedef struct packed {
        logic [3:0]  req_type;
        logic [7:0]  msg_code;
        logic [19:0] pad;
        logic [31:0] payload;
    } cq_msg_t;

    typedef union packed {
        cq_mem_t mem;
        cq_msg_t msg;
    } cq_desc_t;

    // decoded register access.
    typedef struct packed {
        logic                       wr;
        logic [BAR0_ADDR_WIDTH-1:0] idx;
        logic [7:0]                 tag;
        logic [31:0]                wr_data;
    } reg_access_t;

    typedef enum logic [2:0] {
        CPL_SC = 3'd0,
        CPL_UR = 3'd1
    } cpl_status_t;

    // completion word on the cc port.
    typedef struct packed {
        logic [7:0]  tag;
        cpl_status_t status;
        logic [31:0] data;
    } cpl_t;

endpackage

/* fpga_core.f */
design/pcie_example_pkg.sv
design/cq_request_decoder.sv
design/bar_register_file.sv
design/cc_completion_builder.sv
design/example_core_pcie.sv
design/fpga_core.sv
sim/fpga_core_tb.sv

/* sim/fpga_core_tb.sv */
// PCIe completer core testbench
`timescale 1ns/1ns

module fpga_core_tb;
    import pcie_example_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int N_WR  = 32;
    localparam int N_RD  = 32;
    localparam int N_B2B = 64;
    localparam int N_UR  = 24;
    localparam int N_ERR = 10;  // rounds of six bad or checking requests.
    localparam int N_LED = 8;
    localparam int N_MIX = 200;
    localparam int DRAIN = 6;
    // worst case slots per test with gaps.
    localparam int MAX_CYCLES = RESET_CYCLES + N_WR + N_RD + 4 * N_B2B + N_UR + 6 * N_ERR
                              + 3 * N_LED + 2 * N_MIX + 6 * DRAIN + 100;

    typedef struct packed {
        logic [31:0] due;
        cpl_t        cpl;
    } exp_cpl_t;

    typedef struct packed {
        logic [31:0] due;
        logic [3:0]  val;
    } exp_led_t;

    logic        clk;
    logic        reset;
    cq_desc_t    cq_desc;
    logic        cq_valid;
    cpl_t        cc_cpl;
    logic        cc_valid;
    logic [1:0]  user_led_g;
    logic        user_led_r;
    logic [1:0]  front_led;
    logic        status_error_uncor;
    logic [31:0] cycle = '0;

    logic [31:0] model_regs [BAR0_REG_COUNT];
    logic [3:0]  model_led;
    logic        model_err;
    exp_cpl_t    cpl_q[$];
    logic [31:0] err_q[$];
    exp_led_t    led_q[$];
    int          errors;
    int          test_errors;
    int          requests;
    int          completions;

    fpga_core fpga_core_inst (
        .clk                (clk),
        .reset              (reset),
        .cq_desc            (cq_desc),
        .cq_valid           (cq_valid),
        .cc_cpl             (cc_cpl),
        .cc_valid           (cc_valid),
        .user_led_g         (user_led_g),
        .user_led_r         (user_led_r),
        .front_led          (front_led),
        .status_error_uncor (status_error_uncor)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 32'd1;

    initial begin
        while (cycle < 32'(MAX_CYCLES)) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error: %s is 0x%0h, expected 0x%0h at cycle %0d", name, got, exp, cycle);
        errors++;
        test_errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s at cycle %0d", msg, cycle);
        errors++;
        test_errors++;
    endtask

    function automatic cq_desc_t mem_desc(input logic [3:0] req_type, input logic [2:0] bar_id,
                                          input logic [7:0] tag, input logic [15:0] addr,
                                          input logic [31:0] wr_data);
        cq_desc_t d;
        d.mem.req_type = req_type;
        d.mem.bar_id   = bar_id;
        d.mem.tag      = tag;
        d.mem.addr     = addr;
        d.mem.pad      = 1'b0;
        d.mem.wr_data  = wr_data;
        return d;
    endfunction

    function automatic cq_desc_t msg_desc(input logic [7:0] code, input logic [31:0] payload);
        cq_desc_t d;
        d.msg.req_type = REQ_MSG;
        d.msg.msg_code = code;
        d.msg.pad      = 20'($urandom);
        d.msg.payload  = payload;
        return d;
    endfunction

    function automatic logic [15:0] addr_in_bar();
        return 16'($urandom_range(0, BAR0_REG_COUNT - 1));
    endfunction

    function automatic logic [15:0] addr_outside();
        return {12'($urandom_range(1, 4095)), 4'($urandom)};
    endfunction

    function automatic cq_desc_t random_request();
        cq_desc_t    d;
        logic [7:0]  tag;
        logic [31:0] data;
        tag  = 8'($urandom);
        data = $urandom;
        case ($urandom_range(0, 7))
            0, 1:    d = mem_desc(REQ_MEM_WR, BAR0_ID, tag, addr_in_bar(), data);
            2, 3:    d = mem_desc(REQ_MEM_RD, BAR0_ID, tag, addr_in_bar(), data);
            4:       d = mem_desc(REQ_MEM_RD, 3'($urandom), tag, 16'($urandom), data);
            5:       d = msg_desc(MSG_LED_SET, data);
            6:       d = msg_desc(8'($urandom), data);
            default: d = mem_desc(4'($urandom_range(3, 15)), 3'($urandom), tag, 16'($urandom), data);
        endcase
        return d;
    endfunction

    // expected response to one request as seen from the cq port.
    task automatic model_request(input cq_desc_t d);
        logic     hit;
        exp_cpl_t e;
        exp_led_t l;
        hit = (d.mem.bar_id == 3'd0) && (d.mem.addr < 16'(BAR0_REG_COUNT));
        requests++;
        case (d.mem.req_type)
            REQ_MEM_RD: begin
                e.due     = cycle + 32'(CPL_LATENCY);
                e.cpl.tag = d.mem.tag;
                if (hit) begin
                    e.cpl.status = CPL_SC;
                    e.cpl.data   = model_regs[d.mem.addr[3:0]];
                end else begin
                    e.cpl.status = CPL_UR;
                    e.cpl.data   = '0;
                    err_q.push_back(cycle + 32'd2);
                end
                cpl_q.push_back(e);
            end
            REQ_MEM_WR: begin
                if (hit) model_regs[d.mem.addr[3:0]] = d.mem.wr_data;
                else err_q.push_back(cycle + 32'd2);  // dropped.
            end
            REQ_MSG: begin
                if (d.msg.msg_code == MSG_LED_SET) begin
                    l.due = cycle + 32'd2;
                    l.val = d.msg.payload[3:0];
                    led_q.push_back(l);
                end else begin
                    err_q.push_back(cycle + 32'd2);
                end
            end
            default: err_q.push_back(cycle + 32'd2);
        endcase
    endtask

    task automatic check_outputs();
        exp_cpl_t e;
        logic     exp_valid;
        logic     exp_pulse;
        exp_valid = 1'b0;
        exp_pulse = 1'b0;
        while (cpl_q.size() > 0 && cpl_q[0].due < cycle) begin
            e = cpl_q.pop_front();
            report_failure($sformatf("completion for tag 0x%0h never arrived", e.cpl.tag));
        end
        if (cpl_q.size() > 0 && cpl_q[0].due == cycle) begin
            e = cpl_q.pop_front();
            exp_valid = 1'b1;
        end
        assert (cc_valid == exp_valid)
            else report_mismatch("cc_valid", 32'(cc_valid), 32'(exp_valid));
        if (cc_valid && exp_valid) begin
            completions++;
            assert (cc_cpl.tag == e.cpl.tag)
                else report_mismatch("cc_cpl.tag", 32'(cc_cpl.tag), 32'(e.cpl.tag));
            assert (cc_cpl.status == e.cpl.status)
                else report_mismatch("cc_cpl.status", 32'(cc_cpl.status), 32'(e.cpl.status));
            assert (cc_cpl.data == e.cpl.data)
                else report_mismatch("cc_cpl.data", cc_cpl.data, e.cpl.data);
        end
        if (err_q.size() > 0 && err_q[0] == cycle) begin
            void'(err_q.pop_front());
            exp_pulse = 1'b1;
            model_err = 1'b1;  // sticky.
        end
        if (led_q.size() > 0 && led_q[0].due == cycle) begin
            model_led = led_q[0].val;
            void'(led_q.pop_front());
        end
        assert (status_error_uncor == exp_pulse)
            else report_mismatch("status_error_uncor", 32'(status_error_uncor), 32'(exp_pulse));
        assert (user_led_r == model_err)
            else report_mismatch("user_led_r", 32'(user_led_r), 32'(model_err));
        assert ({front_led, user_led_g} == model_led)
            else report_mismatch("{front_led, user_led_g}", 32'({front_led, user_led_g}),
                                 32'(model_led));
    endtask

    task automatic send(input cq_desc_t d);
        @(negedge clk);
        check_outputs();
        cq_desc  = d;
        cq_valid = 1'b1;
        model_request(d);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            check_outputs();
            cq_desc  = cq_desc_t'({$urandom, $urandom});  // noise while idle.
            cq_valid = 1'b0;
        end
    endtask

    task automatic end_test(input int num, input string name);
        idle(DRAIN);
        assert (cpl_q.size() == 0 && err_q.size() == 0 && led_q.size() == 0)
            else report_failure("expected responses still outstanding after drain");
        $display("test %0d %-14s %s, %0d errors", num, name,
                 (test_errors == 0) ? "ok" : "FAILED", test_errors);
        test_errors = 0;
    endtask

    initial begin
        logic [15:0] idx;
        logic [7:0]  code;
        void'($urandom(20));
        cq_desc     = '0;
        cq_valid    = 1'b0;
        reset       = 1'b1;
        model_led   = '0;
        model_err   = 1'b0;
        errors      = 0;
        test_errors = 0;
        requests    = 0;
        completions = 0;
        for (int i = 0; i < BAR0_REG_COUNT; i++) model_regs[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < N_WR; i++)
            send(mem_desc(REQ_MEM_WR, BAR0_ID, 8'($urandom), addr_in_bar(), $urandom));
        for (int i = 0; i < N_RD; i++)
            send(mem_desc(REQ_MEM_RD, BAR0_ID, 8'($urandom), 16'(i % BAR0_REG_COUNT), $urandom));
        end_test(1, "write_read");

        for (int i = 0; i < N_B2B; i++) begin
            send(mem_desc(REQ_MEM_RD, BAR0_ID, 8'(i), addr_in_bar(), $urandom));
            idle(int'($urandom_range(0, 3)));
        end
        end_test(2, "back_to_back");

        for (int i = 0; i < N_UR; i++) begin
            if (i % 2 == 0)
                send(mem_desc(REQ_MEM_RD, BAR0_ID, 8'($urandom), addr_outside(), $urandom));
            else
                send(mem_desc(REQ_MEM_RD, 3'($urandom_range(1, 7)), 8'($urandom),
                              addr_in_bar(), $urandom));
        end
        end_test(3, "unsupported_rd");

        for (int i = 0; i < N_ERR; i++) begin
            idx  = addr_in_bar();
            code = 8'($urandom);
            if (code == MSG_LED_SET) code = 8'h11;
            send(mem_desc(REQ_MEM_WR, BAR0_ID, 8'($urandom),
                          {12'($urandom_range(1, 4095)), idx[3:0]}, $urandom));
            send(mem_desc(REQ_MEM_WR, 3'($urandom_range(1, 7)), 8'($urandom), idx, $urandom));
            send(mem_desc(REQ_MEM_RD, BAR0_ID, 8'($urandom), idx, $urandom)); // still old value.
            send(mem_desc(REQ_MEM_RD, BAR0_ID, 8'($urandom), addr_outside(), $urandom));
            send(mem_desc(4'($urandom_range(3, 15)), 3'($urandom), 8'($urandom),
                          16'($urandom), $urandom));
            send(msg_desc(code, $urandom));
        end
        idle(DRAIN);
        assert (user_led_r) else report_failure("red error LED not set after errors");
        end_test(4, "error_signal");

        for (int i = 0; i < N_LED; i++) begin
            send(msg_desc(MSG_LED_SET, $urandom));
            idle(2);
        end
        for (int i = 0; i < N_MIX; i++) begin
            send(random_request());
            idle(int'($urandom_range(0, 1)));
        end
        end_test(5, "led_and_mixed");

        $display("tests 5, requests %0d, completions %0d, errors %0d",
                 requests, completions, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
